// ==== build.f ====
+incdir+tb
verilog/snap_pkg.sv
verilog/wb_slave_port.sv
verilog/snapshot_reg_mem.sv
verilog/entry_table.sv
verilog/table_ctrl_regs.sv
verilog/table_bridge_top.sv
tb/tb_table_bridge.sv

// ==== tb/tb_wb_tasks.svh ====
// wishbone classic master cycle, request held until wb_ack is sampled
task automatic bus_cycle(input snap_pkg::wb_adr_t adr, input logic we,
                         input snap_pkg::data_t dat);
   @(posedge clk);
   wb_cyc   <= 1'b1;
   wb_stb   <= 1'b1;
   wb_we    <= we;
   wb_adr   <= adr;
   wb_dat_w <= dat;
   num_acc = num_acc + 1;
   @(posedge clk);
   while (!wb_ack) begin
      @(posedge clk);
   end
   wb_cyc <= 1'b0;
   wb_stb <= 1'b0;
endtask

// address map: bit 7 region, bits 6:3 entry, bit 2 word
function automatic snap_pkg::wb_adr_t table_adr(input snap_pkg::entry_idx_t idx,
                                               input logic word);
   return {1'b0, idx, word, 2'b00};
endfunction

function automatic snap_pkg::wb_adr_t ctrl_adr(input logic [6:0] off);
   return {1'b1, off};
endfunction

// lcg, numerical recipes constants
function automatic snap_pkg::data_t next_rand();
   rand_state = rand_state * 32'd1664525 + 32'd1013904223;
   return rand_state;
endfunction

// ==== tb/tb_table_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_table_bridge;

   localparam int CLK_PERIOD  = 10;
   localparam int MEM_LATENCY = 2;
   localparam int N_ENT       = 16;
   localparam int N_RAND      = 16;
   localparam int N_HOLD      = 8;
   localparam int N_WP        = 4;
   localparam int NUM_ACC     = 2*N_ENT + 4*N_ENT + 4*N_RAND + 5*N_HOLD
                                + 7 + 3*N_WP + 2*N_ENT + 11;

   logic                clk = 1'b0;
   logic                rst_n;
   logic                wb_cyc;
   logic                wb_stb;
   logic                wb_we;
   snap_pkg::wb_adr_t   wb_adr;
   snap_pkg::data_t     wb_dat_w;
   snap_pkg::data_t     wb_dat_r;
   logic                wb_ack;

   // reference model
   snap_pkg::mem_word_t model_mem [N_ENT];
   logic [N_ENT-1:0]    model_valid;
   snap_pkg::upper_t    model_upper;
   logic                model_wp;
   snap_pkg::cnt_t      model_commits;
   snap_pkg::cnt_t      model_drops;

   snap_pkg::data_t     exp_dat;
   logic                chk_rd;
   int                  exp_lat;
   int                  lat_cnt = 0;
   int                  num_acc;
   int                  num_ack = 0;
   int                  errors;
   logic [31:0]         rand_state;
   snap_pkg::entry_idx_t idx;
   snap_pkg::entry_idx_t idx_b;

   always #(CLK_PERIOD/2) clk = ~clk;

   table_bridge_top #(
      .MEM_LATENCY (MEM_LATENCY)
   ) table_bridge_top_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   `include "tb_wb_tasks.svh"

   // cycles since stb went high, and acknowledge count
   always @(posedge clk) begin
      lat_cnt <= wb_stb ? lat_cnt + 1 : 0;
      if (wb_ack) begin
         num_ack <= num_ack + 1;
      end
   end

   a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack && chk_rd |-> wb_dat_r == exp_dat)
      else begin
         errors++;
         $display("[FAIL] %0t wb_dat_r expected %h got %h", $time,
                  $sampled(exp_dat), $sampled(wb_dat_r));
      end

   a_ack_lat: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |-> lat_cnt == exp_lat)
      else begin
         errors++;
         $display("[FAIL] %0t wb_ack latency expected %0d got %0d", $time,
                  $sampled(exp_lat), $sampled(lat_cnt));
      end

   a_ack_stb: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |-> wb_cyc && wb_stb)
      else begin
         errors++;
         $display("%0t wb_ack raised outside an active bus cycle", $time);
      end

   a_ack_once: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |=> !wb_ack)
      else begin
         errors++;
         $display("%0t wb_ack held for more than one cycle", $time);
      end

   // expected values follow the snapshot rules, then the cycle runs
   task automatic tbl_access(input snap_pkg::entry_idx_t i, input logic word,
                             input logic we, input snap_pkg::data_t dat);
      chk_rd  = !we;
      exp_lat = 3;
      if (word && we) begin
         model_upper = dat[3:0];
      end else if (word) begin
         exp_dat = {28'b0, model_upper};
      end else if (!we) begin
         exp_lat     = MEM_LATENCY + 3;
         exp_dat     = model_valid[i] ? model_mem[i][31:0] : '0;
         model_upper = model_valid[i] ? model_mem[i][35:32] : '0;
      end else if (model_wp) begin
         model_drops++;
      end else begin
         exp_lat        = MEM_LATENCY + 3;
         model_mem[i]   = {model_upper, dat};
         model_valid[i] = 1'b1;
         model_commits++;
      end
      bus_cycle(table_adr(i, word), we, dat);
   endtask

   task automatic ctrl_access(input logic [6:0] off, input logic we,
                              input snap_pkg::data_t dat);
      chk_rd  = !we;
      exp_lat = 3;
      exp_dat = '0;
      if (we && off == snap_pkg::ctrl_off_wp) begin
         model_wp = dat[0];
      end else if (we && off == snap_pkg::ctrl_off_cnt) begin
         model_commits = '0;
         model_drops   = '0;
      end else if (we && off == snap_pkg::ctrl_off_inv && dat[0]) begin
         model_valid = '0;
      end else if (!we && off == snap_pkg::ctrl_off_wp) begin
         exp_dat = {31'b0, model_wp};
      end else if (!we && off == snap_pkg::ctrl_off_cnt) begin
         exp_dat = {model_drops, model_commits};
      end
      bus_cycle(ctrl_adr(off), we, dat);
   endtask

   initial begin
      rand_state    = 32'h7fd30ff7;
      errors        = 0;
      num_acc       = 0;
      model_valid   = '0;
      model_upper   = '0;
      model_wp      = 1'b0;
      model_commits = '0;
      model_drops   = '0;
      exp_dat       = '0;
      exp_lat       = 0;
      chk_rd        = 1'b0;
      rst_n         = 1'b0;
      wb_cyc        = 1'b0;
      wb_stb        = 1'b0;
      wb_we         = 1'b0;
      wb_adr        = '0;
      wb_dat_w      = '0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      // empty table after reset
      for (int i = 0; i < N_ENT; i++) begin
         tbl_access(4'(i), 1'b0, 1'b0, '0);
         tbl_access(4'(i), 1'b1, 1'b0, '0);
      end

      // fill in one order, read back in another
      for (int i = 0; i < N_ENT; i++) begin
         idx = 4'(i * 3 + 1);
         tbl_access(idx, 1'b1, 1'b1, next_rand());
         tbl_access(idx, 1'b0, 1'b1, next_rand());
      end
      for (int i = 0; i < N_ENT; i++) begin
         idx = 4'(i * 5 + 2);
         tbl_access(idx, 1'b0, 1'b0, '0);
         tbl_access(idx, 1'b1, 1'b0, '0);
      end
      for (int i = 0; i < N_RAND; i++) begin
         idx = 4'(next_rand() >> 7);
         tbl_access(idx, 1'b1, 1'b1, next_rand());
         tbl_access(idx, 1'b0, 1'b1, next_rand());
         tbl_access(idx, 1'b0, 1'b0, '0);
         tbl_access(idx, 1'b1, 1'b0, '0);
      end

      // snapshot survives a commit to another entry
      for (int i = 0; i < N_HOLD; i++) begin
         idx   = 4'(next_rand() >> 11);
         idx_b = idx + 4'(i + 1);
         tbl_access(idx, 1'b0, 1'b0, '0);
         tbl_access(idx_b, 1'b0, 1'b1, next_rand());
         tbl_access(idx, 1'b1, 1'b0, '0);
         tbl_access(idx_b, 1'b0, 1'b0, '0);
         tbl_access(idx_b, 1'b1, 1'b0, '0);
      end

      // write protect
      ctrl_access(snap_pkg::ctrl_off_cnt, 1'b1, '0);
      ctrl_access(snap_pkg::ctrl_off_wp, 1'b1, 32'h1);
      for (int i = 0; i < N_WP; i++) begin
         idx = 4'(next_rand() >> 5);
         tbl_access(idx, 1'b0, 1'b1, next_rand());
         tbl_access(idx, 1'b0, 1'b0, '0);
         tbl_access(idx, 1'b1, 1'b0, '0);
      end
      ctrl_access(snap_pkg::ctrl_off_cnt, 1'b0, '0);
      ctrl_access(snap_pkg::ctrl_off_wp, 1'b0, '0);
      ctrl_access(snap_pkg::ctrl_off_wp, 1'b1, '0);
      tbl_access(idx, 1'b0, 1'b1, next_rand());
      ctrl_access(snap_pkg::ctrl_off_cnt, 1'b0, '0);

      // invalidate all, then commit two entries again
      ctrl_access(snap_pkg::ctrl_off_inv, 1'b1, 32'h1);
      for (int i = 0; i < N_ENT; i++) begin
         tbl_access(4'(i), 1'b0, 1'b0, '0);
         tbl_access(4'(i), 1'b1, 1'b0, '0);
      end
      for (int i = 0; i < 2; i++) begin
         idx = 4'(i * 9);
         tbl_access(idx, 1'b1, 1'b1, next_rand());
         tbl_access(idx, 1'b0, 1'b1, next_rand());
         tbl_access(idx, 1'b0, 1'b0, '0);
         tbl_access(idx, 1'b1, 1'b0, '0);
      end
      ctrl_access(snap_pkg::ctrl_off_inv, 1'b0, '0);
      ctrl_access(7'h0c, 1'b0, '0);

      repeat (4) @(posedge clk);
      if (num_ack != num_acc) begin
         errors++;
         $display("acknowledge count does not match the number of accesses");
      end
      $display("accesses %0d, acknowledges %0d, errors %0d", num_acc, num_ack, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   initial begin
      #(CLK_PERIOD * (NUM_ACC * (MEM_LATENCY + 8) + 50));
      $display("watchdog expired waiting for wb_ack, accesses %0d, acknowledges %0d, errors %0d",
               num_acc, num_ack, errors);
      $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/entry_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module entry_table #(
   parameter int MEM_LATENCY = 2
) (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire snap_pkg::tbl_req_t  req,
   output snap_pkg::tbl_rsp_t       rsp,
   input  wire logic                inv_all
);

   localparam int ENTRIES = 2 ** $bits(snap_pkg::entry_idx_t);

   snap_pkg::mem_word_t    mem [ENTRIES];
   snap_pkg::mem_word_t    rd_q;
   logic [ENTRIES-1:0]     valid;
   logic [MEM_LATENCY-1:0] ack_sr;
   logic                   strobe;

   assign strobe = req.rd | req.wr;

   always_ff @(posedge clk) begin
      if (req.wr) begin
         mem[req.idx] <= req.wdata;
      end
   end

   // sampled at the strobe so a later invalidate does not affect it
   always_ff @(posedge clk) begin
      if (req.rd) begin
         rd_q <= valid[req.idx] ? mem[req.idx] : '0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid <= '0;
      end else begin
         if (inv_all) begin
            valid <= '0;
         end
         if (req.wr) begin
            valid[req.idx] <= 1'b1;
         end
      end
   end

   // ack delay line
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack_sr <= '0;
      end else begin
         ack_sr[0] <= strobe;
         for (int i = 1; i < MEM_LATENCY; i++) begin
            ack_sr[i] <= ack_sr[i-1];
         end
      end
   end

   assign rsp.ack   = ack_sr[MEM_LATENCY-1];
   assign rsp.rdata = rd_q;

   a_single_access: assert property (@(posedge clk) disable iff (!rst_n)
      strobe |-> !(|ack_sr));

endmodule

`default_nettype wire

// ==== verilog/snap_pkg.sv ====
`default_nettype none

package snap_pkg;

   // address map (byte address, 8 bits)
   //   bit 7      region select, 0 = table window, 1 = control registers
   //   bits 6:3   table entry
   //   bit 2      word within the entry

   typedef logic [31:0] data_t;
   typedef logic [35:0] mem_word_t;
   typedef logic [3:0]  upper_t;
   typedef logic [3:0]  entry_idx_t;
   typedef logic [7:0]  wb_adr_t;
   typedef logic [15:0] cnt_t;

   // one decoded access handed to a block
   typedef struct packed {
      logic [6:0] off;
      logic       we;
      data_t      wdata;
      logic       stb;
   } blk_req_t;

   typedef struct packed {
      logic  ack;
      data_t rdata;
   } blk_rsp_t;

   typedef struct packed {
      entry_idx_t idx;
      logic       rd;
      logic       wr;
      mem_word_t  wdata;
   } tbl_req_t;

   // rdata is zero for an invalid entry
   typedef struct packed {
      logic      ack;
      mem_word_t rdata;
   } tbl_rsp_t;

   typedef enum logic [1:0] {snap_idle, snap_fetch, snap_op} snap_state_t;
   typedef enum logic [1:0] {port_idle, port_wait, port_ack} port_state_t;

   localparam logic [6:0] ctrl_off_wp  = 7'h00;
   localparam logic [6:0] ctrl_off_cnt = 7'h04;
   localparam logic [6:0] ctrl_off_inv = 7'h08;

endpackage

`default_nettype wire

// ==== verilog/snapshot_reg_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module snapshot_reg_mem (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire snap_pkg::blk_req_t  req,
   output snap_pkg::blk_rsp_t       rsp,
   input  wire logic                write_protect,
   output snap_pkg::tbl_req_t       tbl_req,
   input  wire snap_pkg::tbl_rsp_t  tbl_rsp,
   output logic                     commit_done,
   output logic                     commit_dropped
);

   localparam int PAD_W = $bits(snap_pkg::data_t) - $bits(snap_pkg::upper_t);

   snap_pkg::snap_state_t state;
   snap_pkg::upper_t      snap_upper;
   snap_pkg::data_t       rdata_q;
   logic                  word_q;
   logic                  we_q;
   logic                  word_sel;
   logic                  start;
   logic                  fetch;
   logic                  drop;

   // bit 2 picks the word, bits 6:3 the entry
   assign word_sel = req.off[2];
   assign start    = (state == snap_pkg::snap_idle) && req.stb;

   // word 0 reads and unprotected word 0 writes touch the table
   assign fetch = !word_sel && (!req.we || !write_protect);
   assign drop  = !word_sel && req.we && write_protect;

   // strobe goes out in the request cycle so the table latency starts at once
   always_comb begin
      tbl_req.idx   = req.off[6:3];
      tbl_req.rd    = start && fetch && !req.we;
      tbl_req.wr    = start && fetch && req.we;
      tbl_req.wdata = {snap_upper, req.wdata};
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= snap_pkg::snap_idle;
         snap_upper <= '0;
         word_q     <= 1'b0;
         we_q       <= 1'b0;
      end else begin
         case (state)
            snap_pkg::snap_idle: begin
               if (req.stb) begin
                  word_q <= word_sel;
                  we_q   <= req.we;
                  if (word_sel && req.we) begin
                     snap_upper <= req.wdata[$bits(snap_pkg::upper_t)-1:0];
                  end
                  if (fetch) begin
                     state <= snap_pkg::snap_fetch;
                  end else begin
                     state <= snap_pkg::snap_op;
                  end
               end
            end
            snap_pkg::snap_fetch: begin
               if (tbl_rsp.ack) begin
                  // a read refreshes the upper bits of the snapshot
                  if (!we_q) begin
                     snap_upper <= tbl_rsp.rdata[35:32];
                  end
                  state <= snap_pkg::snap_op;
               end
            end
            snap_pkg::snap_op: begin
               state <= snap_pkg::snap_idle;
            end
            default: begin
               state <= snap_pkg::snap_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == snap_pkg::snap_fetch && tbl_rsp.ack) begin
         rdata_q <= tbl_rsp.rdata[31:0];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         commit_done    <= 1'b0;
         commit_dropped <= 1'b0;
      end else begin
         commit_done    <= (state == snap_pkg::snap_fetch) && tbl_rsp.ack && we_q;
         commit_dropped <= start && drop;
      end
   end

   // word 1 is served from the snapshot, zero-padded
   always_comb begin
      rsp.ack = (state == snap_pkg::snap_op);
      if (word_q) begin
         rsp.rdata = {{PAD_W{1'b0}}, snap_upper};
      end else begin
         rsp.rdata = rdata_q;
      end
   end

   a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      !(tbl_req.rd && tbl_req.wr));

   // table answers only while a fetch waits for it
   a_ack_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
      tbl_rsp.ack |-> state == snap_pkg::snap_fetch);

endmodule

`default_nettype wire

// ==== verilog/table_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module table_bridge_top #(
   parameter int MEM_LATENCY = 2
) (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire logic               wb_cyc,
   input  wire logic               wb_stb,
   input  wire logic               wb_we,
   input  wire snap_pkg::wb_adr_t  wb_adr,
   input  wire snap_pkg::data_t    wb_dat_w,
   output snap_pkg::data_t         wb_dat_r,
   output logic                    wb_ack
);

   snap_pkg::blk_req_t tbl_win_req;
   snap_pkg::blk_req_t ctrl_req;
   snap_pkg::blk_rsp_t tbl_win_rsp;
   snap_pkg::blk_rsp_t ctrl_rsp;
   snap_pkg::tbl_req_t tbl_req;
   snap_pkg::tbl_rsp_t tbl_rsp;
   logic               write_protect;
   logic               inv_all;
   logic               commit_done;
   logic               commit_dropped;

   wb_slave_port u_port (
      .clk         (clk),
      .rst_n       (rst_n),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .tbl_win_req (tbl_win_req),
      .ctrl_req    (ctrl_req),
      .tbl_win_rsp (tbl_win_rsp),
      .ctrl_rsp    (ctrl_rsp)
   );

   snapshot_reg_mem u_snap (
      .clk            (clk),
      .rst_n          (rst_n),
      .req            (tbl_win_req),
      .rsp            (tbl_win_rsp),
      .write_protect  (write_protect),
      .tbl_req        (tbl_req),
      .tbl_rsp        (tbl_rsp),
      .commit_done    (commit_done),
      .commit_dropped (commit_dropped)
   );

   entry_table #(
      .MEM_LATENCY (MEM_LATENCY)
   ) u_table (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (tbl_req),
      .rsp     (tbl_rsp),
      .inv_all (inv_all)
   );

   table_ctrl_regs u_ctrl (
      .clk            (clk),
      .rst_n          (rst_n),
      .req            (ctrl_req),
      .rsp            (ctrl_rsp),
      .write_protect  (write_protect),
      .inv_all        (inv_all),
      .commit_done    (commit_done),
      .commit_dropped (commit_dropped)
   );

endmodule

`default_nettype wire

// ==== verilog/table_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module table_ctrl_regs (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire snap_pkg::blk_req_t  req,
   output snap_pkg::blk_rsp_t       rsp,
   output logic                     write_protect,
   output logic                     inv_all,
   input  wire logic                commit_done,
   input  wire logic                commit_dropped
);

   snap_pkg::cnt_t  commit_cnt;
   snap_pkg::cnt_t  drop_cnt;
   snap_pkg::data_t rd_val;
   snap_pkg::data_t rdata_q;
   logic            ack_q;
   logic            wr_stb;

   assign wr_stb = req.stb && req.we;

   always_comb begin
      case (req.off)
         snap_pkg::ctrl_off_wp:  rd_val = {31'b0, write_protect};
         snap_pkg::ctrl_off_cnt: rd_val = {drop_cnt, commit_cnt};
         default:                rd_val = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         write_protect <= 1'b0;
         inv_all       <= 1'b0;
         ack_q         <= 1'b0;
      end else begin
         ack_q   <= req.stb;
         inv_all <= wr_stb && (req.off == snap_pkg::ctrl_off_inv) && req.wdata[0];
         if (wr_stb && req.off == snap_pkg::ctrl_off_wp) begin
            write_protect <= req.wdata[0];
         end
      end
   end

   // counters wrap and any write to the count register clears both
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         commit_cnt <= '0;
         drop_cnt   <= '0;
      end else if (wr_stb && req.off == snap_pkg::ctrl_off_cnt) begin
         commit_cnt <= '0;
         drop_cnt   <= '0;
      end else begin
         if (commit_done) begin
            commit_cnt <= commit_cnt + 1'b1;
         end
         if (commit_dropped) begin
            drop_cnt <= drop_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req.stb) begin
         rdata_q <= rd_val;
      end
   end

   assign rsp.ack   = ack_q;
   assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/wb_slave_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_slave_port (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire logic                wb_cyc,
   input  wire logic                wb_stb,
   input  wire logic                wb_we,
   input  wire snap_pkg::wb_adr_t   wb_adr,
   input  wire snap_pkg::data_t     wb_dat_w,
   output snap_pkg::data_t          wb_dat_r,
   output logic                     wb_ack,
   output snap_pkg::blk_req_t       tbl_win_req,
   output snap_pkg::blk_req_t       ctrl_req,
   input  wire snap_pkg::blk_rsp_t  tbl_win_rsp,
   input  wire snap_pkg::blk_rsp_t  ctrl_rsp
);

   snap_pkg::port_state_t state;
   snap_pkg::blk_req_t    req_q;
   logic                  sel_ctrl;
   logic                  blk_ack;

   assign blk_ack = tbl_win_rsp.ack | ctrl_rsp.ack;

   // one captured access, strobe routed by the region bit
   always_comb begin
      tbl_win_req     = req_q;
      tbl_win_req.stb = req_q.stb & ~sel_ctrl;
      ctrl_req        = req_q;
      ctrl_req.stb    = req_q.stb & sel_ctrl;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= snap_pkg::port_idle;
         req_q    <= '0;
         sel_ctrl <= 1'b0;
      end else begin
         req_q.stb <= 1'b0;
         case (state)
            snap_pkg::port_idle: begin
               if (wb_cyc && wb_stb) begin
                  req_q.off   <= wb_adr[6:0];
                  req_q.we    <= wb_we;
                  req_q.wdata <= wb_dat_w;
                  req_q.stb   <= 1'b1;
                  sel_ctrl    <= wb_adr[7];
                  state       <= snap_pkg::port_wait;
               end
            end
            snap_pkg::port_wait: begin
               if (blk_ack) begin
                  state <= snap_pkg::port_ack;
               end
            end
            snap_pkg::port_ack: begin
               state <= snap_pkg::port_idle;
            end
            default: begin
               state <= snap_pkg::port_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == snap_pkg::port_wait && blk_ack) begin
         wb_dat_r <= ctrl_rsp.ack ? ctrl_rsp.rdata : tbl_win_rsp.rdata;
      end
   end

   assign wb_ack = (state == snap_pkg::port_ack);

   a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |-> wb_cyc && wb_stb);

   // blocks answer only to a request that is in flight
   a_no_idle_ack: assert property (@(posedge clk) disable iff (!rst_n)
      state == snap_pkg::port_idle |-> !(tbl_win_rsp.ack || ctrl_rsp.ack));

endmodule

`default_nettype wire
